//--- include/tag_store_settings.svh
`ifndef TAG_STORE_SETTINGS_SVH
`define TAG_STORE_SETTINGS_SVH

// Set associativity of the tag store
`define TS_WAYS 4

// Set index width, 2**TS_INDEX_W sets per way
`define TS_INDEX_W 4

// Address tag width stored per line
`define TS_TAG_W 8

// Read latency of one tag macro in cycles
// The controller timing is built around this value
`define TS_READ_LAT 1

`endif

//--- logic/tag_store_pkg.sv
`include "tag_store_settings.svh"

package tag_store_pkg;

  // One bit per way, used both one-hot and as a mask
  typedef logic [`TS_WAYS-1:0] way_ind_t;
  // Binary way number
  typedef logic [$clog2(`TS_WAYS)-1:0] way_idx_t;
  typedef logic [`TS_INDEX_W-1:0] index_t;
  typedef logic [`TS_TAG_W-1:0] tag_t;

  // One entry of a tag macro
  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_data_t;

  typedef enum logic {Lookup, Flush} store_mode_e;

  // Lookup: indicator is the search mask
  // Flush: indicator is the one-hot way to clear
  typedef struct packed {
    store_mode_e mode;
    index_t      index;
    tag_t        tag;
    logic        dirty;
    way_ind_t    indicator;
  } store_req_t;

  typedef struct packed {
    way_ind_t indicator;
    logic     hit;
    logic     evict;
    tag_t     evict_tag;
  } store_res_t;

  typedef enum logic [1:0] {Idle, Read, Resp} ctrl_state_e;

endpackage

//--- logic/tag_macro.sv
`timescale 1ns/1ps
`include "tag_store_settings.svh"

module tag_macro (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  tag_store_pkg::index_t    index_i,
  input  tag_store_pkg::tag_data_t wdata_i,
  output tag_store_pkg::tag_data_t rdata_o
);
  import tag_store_pkg::*;

  localparam int unsigned NumSets = 1 << `TS_INDEX_W;

  // One entry per set for this way
  tag_data_t mem_q [NumSets];
  tag_data_t rdata_q;

  // Write port, whole array cleared on reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NumSets; i++) begin
        mem_q[i] <= '0;
      end
    end else if (req_i && we_i) begin
      mem_q[index_i] <= wdata_i;
    end
  end

  // Registered read, one cycle latency
  // Output keeps the last read across writes and idle cycles
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      rdata_q <= mem_q[index_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- logic/tag_compare.sv
`timescale 1ns/1ps
`include "tag_store_settings.svh"

module tag_compare (
  input  tag_store_pkg::tag_data_t [`TS_WAYS-1:0] rdata_i,
  input  tag_store_pkg::store_req_t               held_req_i,
  input  tag_store_pkg::way_idx_t                 sel_way_i,
  output tag_store_pkg::way_ind_t                 hit_o,
  output tag_store_pkg::way_ind_t                 valid_o,
  output tag_store_pkg::way_ind_t                 dirty_o,
  output tag_store_pkg::tag_data_t                sel_tag_o
);
  import tag_store_pkg::*;

  for (genvar i = 0; i < `TS_WAYS; i++) begin : gen_way
    logic tag_match;

    // Stored tag against the tag of the request in flight
    assign tag_match = (rdata_i[i].tag == held_req_i.tag);

    // State bits straight from the macro
    assign valid_o[i] = rdata_i[i].valid;
    assign dirty_o[i] = rdata_i[i].dirty;

    // Only searched, valid ways can hit
    assign hit_o[i] = held_req_i.indicator[i] & rdata_i[i].valid & tag_match;
  end

  // Entry of the way the controller points at
  // used for evict tag and flush response
  assign sel_tag_o = rdata_i[sel_way_i];

endmodule

//--- logic/evict_select.sv
`timescale 1ns/1ps
`include "tag_store_settings.svh"

module evict_select (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  tag_store_pkg::way_ind_t spm_lock_i,
  input  tag_store_pkg::way_ind_t valid_i,
  input  tag_store_pkg::way_ind_t dirty_i,
  input  logic                    step_i,
  output tag_store_pkg::way_ind_t victim_o,
  output logic                    evict_o,
  output logic                    full_o
);
  import tag_store_pkg::*;

  // Unlocked ways that hold nothing
  way_ind_t free_ways;
  // Round-robin start point
  way_idx_t ptr_q;
  way_idx_t victim_idx;
  logic     found;

  assign free_ways = ~spm_lock_i & ~valid_i;
  assign full_o    = ~|free_ways;

  always_comb begin
    int cand;
    victim_idx = '0;
    found      = 1'b0;
    cand       = 0;
    if (!full_o) begin
      // Scan downward so the last match is the lowest free way
      for (int i = `TS_WAYS - 1; i >= 0; i--) begin
        if (free_ways[i]) begin
          victim_idx = way_idx_t'(i);
          found      = 1'b1;
        end
      end
    end else begin
      // Same trick relative to the pointer, with wraparound
      for (int k = `TS_WAYS - 1; k >= 0; k--) begin
        cand = (int'(ptr_q) + k) % `TS_WAYS;
        if (!spm_lock_i[cand]) begin
          victim_idx = way_idx_t'(cand);
          found      = 1'b1;
        end
      end
    end
  end

  // No victim at all when every way is locked
  assign victim_o = found ? (way_ind_t'(1) << victim_idx) : '0;
  // Write-back needed only when a valid line gets replaced
  assign evict_o  = full_o & found & dirty_i[victim_idx];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (step_i) begin
      // Next search starts one past the way just replaced
      if (victim_idx == way_idx_t'(`TS_WAYS - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= victim_idx + way_idx_t'(1);
      end
    end
  end

endmodule

//--- logic/tag_store_ctrl.sv
`timescale 1ns/1ps
`include "tag_store_settings.svh"

module tag_store_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  tag_store_pkg::store_req_t req_i,
  input  logic                      valid_i,
  output logic                      ready_o,
  output tag_store_pkg::store_res_t res_o,
  output logic                      valid_o,
  input  logic                      ready_i,
  output tag_store_pkg::way_ind_t   ram_req_o,
  output tag_store_pkg::way_ind_t   ram_we_o,
  output tag_store_pkg::index_t     ram_index_o,
  output tag_store_pkg::tag_data_t  ram_wdata_o,
  output tag_store_pkg::store_req_t held_req_o,
  input  tag_store_pkg::way_ind_t   hit_i,
  input  tag_store_pkg::way_ind_t   way_dirty_i,
  output tag_store_pkg::way_idx_t   sel_way_o,
  input  tag_store_pkg::tag_data_t  sel_tag_i,
  input  tag_store_pkg::way_ind_t   victim_i,
  input  logic                      victim_evict_i,
  input  logic                      victim_full_i,
  output logic                      victim_step_o
);
  import tag_store_pkg::*;

  ctrl_state_e state_q, state_d;
  store_req_t  req_q;
  store_res_t  res_q, res_d;
  way_ind_t    sel_ind;
  logic        res_hsk;
  logic        is_lookup;
  logic        any_hit;
  logic        lookup_evict;
  logic        hit_upgrade;

  function automatic way_idx_t ind_to_idx(input way_ind_t ind);
    way_idx_t idx;
    idx = '0;
    for (int i = 0; i < `TS_WAYS; i++) begin
      if (ind[i]) begin
        idx = idx | way_idx_t'(i);
      end
    end
    return idx;
  endfunction

  // One request in flight, accepted only from Idle
  assign ready_o    = (state_q == Idle);
  assign valid_o    = (state_q == Resp);
  assign res_hsk    = valid_o & ready_i;
  assign res_o      = res_q;
  assign held_req_o = req_q;
  assign is_lookup  = (req_q.mode == Lookup);
  assign any_hit    = |hit_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: if (valid_i) state_d = Read;
      // Macro data is valid for exactly this cycle's decision
      Read: state_d = Resp;
      Resp: if (ready_i) state_d = Idle;
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Request held from acceptance to the response handshake
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      req_q <= req_i;
    end
  end

  // Way the response refers to, also the comparator's output select
  always_comb begin
    if (state_q == Resp) begin
      sel_ind = res_q.indicator;
    end else if (!is_lookup) begin
      sel_ind = req_q.indicator;
    end else if (any_hit) begin
      sel_ind = hit_i;
    end else begin
      sel_ind = victim_i;
    end
  end

  assign sel_way_o    = ind_to_idx(sel_ind);
  assign lookup_evict = ~any_hit & victim_evict_i;

  always_comb begin
    res_d = '0;
    res_d.indicator = sel_ind;
    if (is_lookup) begin
      res_d.hit       = any_hit;
      res_d.evict     = lookup_evict;
      res_d.evict_tag = lookup_evict ? sel_tag_i.tag : '0;
    end else begin
      // Flush reports what was in the way before clearing it
      res_d.evict     = sel_tag_i.valid & sel_tag_i.dirty;
      res_d.evict_tag = sel_tag_i.tag;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == Read) begin
      res_q <= res_d;
    end
  end

  // Clean line hit by a dirty access needs its dirty bit set
  assign hit_upgrade = req_q.dirty & ~|(way_dirty_i & res_q.indicator);

  always_comb begin
    ram_req_o   = '0;
    ram_we_o    = '0;
    ram_index_o = req_q.index;
    ram_wdata_o = '0;
    if (state_q == Idle) begin
      // Read issued at the accepting edge
      ram_index_o = req_i.index;
      if (valid_i) begin
        ram_req_o = req_i.indicator;
      end
    end else if (res_hsk) begin
      if (!is_lookup) begin
        // Flush writes all zeros
        ram_req_o = res_q.indicator;
        ram_we_o  = res_q.indicator;
      end else if (!res_q.hit || hit_upgrade) begin
        ram_req_o   = res_q.indicator;
        ram_we_o    = res_q.indicator;
        ram_wdata_o = '{valid: 1'b1, dirty: req_q.dirty, tag: req_q.tag};
      end
    end
  end

  // Pointer moves only when a valid line was replaced
  assign victim_step_o = res_hsk & is_lookup & ~res_q.hit & victim_full_i;

endmodule

//--- logic/tag_store.sv
`timescale 1ns/1ps
`include "tag_store_settings.svh"

module tag_store (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  tag_store_pkg::way_ind_t   spm_lock_i,
  input  tag_store_pkg::store_req_t req_i,
  input  logic                      valid_i,
  output logic                      ready_o,
  output tag_store_pkg::store_res_t res_o,
  output logic                      valid_o,
  input  logic                      ready_i
);
  import tag_store_pkg::*;

  // Macro side
  way_ind_t                 ram_req;
  way_ind_t                 ram_we;
  index_t                   ram_index;
  tag_data_t                ram_wdata;
  tag_data_t [`TS_WAYS-1:0] ram_rdata;

  // Compare and victim side
  store_req_t held_req;
  way_ind_t   hit;
  way_ind_t   way_valid;
  way_ind_t   way_dirty;
  way_idx_t   sel_way;
  tag_data_t  sel_tag;
  way_ind_t   victim;
  logic       victim_evict;
  logic       victim_full;
  logic       victim_step;

  tag_store_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_i          (req_i),
    .valid_i        (valid_i),
    .ready_o        (ready_o),
    .res_o          (res_o),
    .valid_o        (valid_o),
    .ready_i        (ready_i),
    .ram_req_o      (ram_req),
    .ram_we_o       (ram_we),
    .ram_index_o    (ram_index),
    .ram_wdata_o    (ram_wdata),
    .held_req_o     (held_req),
    .hit_i          (hit),
    .way_dirty_i    (way_dirty),
    .sel_way_o      (sel_way),
    .sel_tag_i      (sel_tag),
    .victim_i       (victim),
    .victim_evict_i (victim_evict),
    .victim_full_i  (victim_full),
    .victim_step_o  (victim_step)
  );

  // One array per way, shared index and write data
  for (genvar i = 0; i < `TS_WAYS; i++) begin : gen_macro
    tag_macro u_macro (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (ram_req[i]),
      .we_i    (ram_we[i]),
      .index_i (ram_index),
      .wdata_i (ram_wdata),
      .rdata_o (ram_rdata[i])
    );
  end

  tag_compare u_compare (
    .rdata_i    (ram_rdata),
    .held_req_i (held_req),
    .sel_way_i  (sel_way),
    .hit_o      (hit),
    .valid_o    (way_valid),
    .dirty_o    (way_dirty),
    .sel_tag_o  (sel_tag)
  );

  evict_select u_evict (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .spm_lock_i (spm_lock_i),
    .valid_i    (way_valid),
    .dirty_i    (way_dirty),
    .step_i     (victim_step),
    .victim_o   (victim),
    .evict_o    (victim_evict),
    .full_o     (victim_full)
  );

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk_o
);

  // 4 ns period, toggles every 2 ns
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

endmodule

//--- test/tag_store_chk.sv
`timescale 1ns/1ps

module tag_store_chk (
  input logic                      clk_i,
  input logic                      rst_n_i,
  input logic                      req_valid_i,
  input logic                      req_ready_i,
  input tag_store_pkg::store_res_t res_i,
  input logic                      res_valid_i,
  input logic                      res_ready_i
);

  // Read by the testbench top
  int unsigned fail_cnt = 0;

  // Response names exactly one way
  ind_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    res_valid_i |-> $onehot(res_i.indicator))
    else begin
      $error("response indicator is not one-hot");
      fail_cnt++;
    end

  // Held response under back-pressure
  res_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (res_valid_i && !res_ready_i) |=> (res_valid_i && $stable(res_i)))
    else begin
      $error("response changed or dropped before ready_i");
      fail_cnt++;
    end

  // Single request in flight, so never both at once
  no_overlap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(req_ready_i && res_valid_i))
    else begin
      $error("ready_o and valid_o high together");
      fail_cnt++;
    end

  // Read one cycle, response register the next
  resp_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(req_valid_i && req_ready_i, 2) |-> $rose(res_valid_i))
    else begin
      $error("valid_o did not rise two cycles after acceptance");
      fail_cnt++;
    end

endmodule

//--- test/tag_store_tb.sv
`timescale 1ns/1ps
`include "tag_store_settings.svh"

module tag_store_tb;
  import tag_store_pkg::*;

  localparam int unsigned NumSets      = 1 << `TS_INDEX_W;
  localparam int unsigned ResetCycles  = 8;
  localparam int unsigned CyclesPerReq = 20;
  localparam way_ind_t    AllWays      = '1;

  // Table row, hand-worked hit and evict in the last two fields
  typedef struct packed {
    store_mode_e mode;
    index_t      index;
    tag_t        tag;
    logic        dirty;
    way_ind_t    ind;
    way_ind_t    lock;
    logic        exp_hit;
    logic        exp_evict;
  } stim_t;

  logic        clk;
  logic        rst_n;
  way_ind_t    spm_lock;
  store_req_t  req;
  logic        req_valid;
  logic        req_ready;
  store_res_t  res;
  logic        res_valid;
  logic        res_ready;

  stim_t       stim_q[$];
  // Reference copy of every set and way, plus the shared round-robin pointer
  tag_data_t   model_q [NumSets][`TS_WAYS];
  int          rr_ptr;
  logic [31:0] lfsr_q;
  int unsigned cycle_cnt = 0;
  int unsigned max_cycles = 0;

  tb_clock u_clock (
    .clk_o (clk)
  );

  tag_store u_tag_store (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .spm_lock_i (spm_lock),
    .req_i      (req),
    .valid_i    (req_valid),
    .ready_o    (req_ready),
    .res_o      (res),
    .valid_o    (res_valid),
    .ready_i    (res_ready)
  );

  bind tag_store tag_store_chk u_chk (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (valid_i),
    .req_ready_i (ready_o),
    .res_i       (res_o),
    .res_valid_i (valid_o),
    .res_ready_i (ready_i)
  );

  task automatic stop_on_failure();
    $display("Test failures found");
    $fatal(1, "simulation stopped after a failure");
  endtask

  task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR: %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      stop_on_failure();
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int unsigned n, output int unsigned v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  // Inputs change 1 ns after the edge, outputs are read there too
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic add_stim(input store_mode_e mode, input int unsigned index,
                          input tag_t tag, input logic dirty, input way_ind_t ind,
                          input way_ind_t lock, input logic exp_hit, input logic exp_evict);
    stim_q.push_back(stim_t'{mode, index_t'(index), tag, dirty, ind, lock, exp_hit, exp_evict});
  endtask

  task automatic build_table();
    // Empty set fill, hit, dirty upgrade, flush with write-back
    add_stim(Lookup, 1, 8'h11, 1'b0, AllWays, 4'b0000, 1'b0, 1'b0);
    add_stim(Lookup, 1, 8'h11, 1'b0, AllWays, 4'b0000, 1'b1, 1'b0);
    add_stim(Lookup, 1, 8'h11, 1'b1, AllWays, 4'b0000, 1'b1, 1'b0);
    add_stim(Flush,  1, 8'h00, 1'b0, 4'b0001, 4'b0000, 1'b0, 1'b1);
    // Flush of empty and clean ways, old tag misses afterwards
    add_stim(Flush,  1, 8'h00, 1'b0, 4'b0001, 4'b0000, 1'b0, 1'b0);
    add_stim(Lookup, 1, 8'h11, 1'b0, AllWays, 4'b0000, 1'b0, 1'b0);
    add_stim(Flush,  1, 8'h00, 1'b0, 4'b0001, 4'b0000, 1'b0, 1'b0);
    add_stim(Lookup, 1, 8'h11, 1'b0, AllWays, 4'b0000, 1'b0, 1'b0);
    // Fill set 2, then round-robin replacement
    add_stim(Lookup, 2, 8'h20, 1'b1, AllWays, 4'b0000, 1'b0, 1'b0);
    add_stim(Lookup, 2, 8'h21, 1'b0, AllWays, 4'b0000, 1'b0, 1'b0);
    add_stim(Lookup, 2, 8'h22, 1'b1, AllWays, 4'b0000, 1'b0, 1'b0);
    add_stim(Lookup, 2, 8'h23, 1'b0, AllWays, 4'b0000, 1'b0, 1'b0);
    add_stim(Lookup, 2, 8'h24, 1'b0, AllWays, 4'b0000, 1'b0, 1'b1);
    add_stim(Lookup, 2, 8'h25, 1'b1, AllWays, 4'b0000, 1'b0, 1'b0);
    add_stim(Lookup, 2, 8'h26, 1'b0, AllWays, 4'b0000, 1'b0, 1'b1);
    add_stim(Lookup, 2, 8'h27, 1'b0, AllWays, 4'b0000, 1'b0, 1'b0);
    add_stim(Lookup, 2, 8'h25, 1'b0, AllWays, 4'b0000, 1'b1, 1'b0);
    // Ways 1 and 2 locked in set 3
    add_stim(Lookup, 3, 8'h30, 1'b1, AllWays, 4'b0110, 1'b0, 1'b0);
    add_stim(Lookup, 3, 8'h31, 1'b1, AllWays, 4'b0110, 1'b0, 1'b0);
    add_stim(Lookup, 3, 8'h32, 1'b0, AllWays, 4'b0110, 1'b0, 1'b1);
    add_stim(Lookup, 3, 8'h33, 1'b0, AllWays, 4'b0110, 1'b0, 1'b1);
    add_stim(Lookup, 3, 8'h34, 1'b1, AllWays, 4'b0110, 1'b0, 1'b0);
    add_stim(Lookup, 3, 8'h35, 1'b0, AllWays, 4'b0110, 1'b0, 1'b0);
    add_stim(Lookup, 3, 8'h36, 1'b0, AllWays, 4'b0001, 1'b0, 1'b0);
    // Mixed flushes and refills
    add_stim(Flush,  2, 8'h00, 1'b0, 4'b0010, 4'b0000, 1'b0, 1'b1);
    add_stim(Lookup, 2, 8'h25, 1'b0, AllWays, 4'b0000, 1'b0, 1'b0);
    add_stim(Flush,  2, 8'h00, 1'b0, 4'b1000, 4'b0000, 1'b0, 1'b0);
    add_stim(Lookup, 3, 8'h35, 1'b1, AllWays, 4'b0000, 1'b1, 1'b0);
    add_stim(Flush,  3, 8'h00, 1'b0, 4'b1000, 4'b0000, 1'b0, 1'b1);
    // Empty way 3 locked, so set 2 counts as full and the pointer wraps
    add_stim(Lookup, 2, 8'h29, 1'b1, AllWays, 4'b1000, 1'b0, 1'b0);
    add_stim(Lookup, 2, 8'h2a, 1'b0, AllWays, 4'b1000, 1'b0, 1'b0);
    add_stim(Lookup, 2, 8'h2b, 1'b0, AllWays, 4'b1000, 1'b0, 1'b0);
    add_stim(Lookup, 2, 8'h2c, 1'b0, AllWays, 4'b1000, 1'b0, 1'b1);
    add_stim(Lookup, 3, 8'h35, 1'b0, AllWays, 4'b0000, 1'b0, 1'b0);
  endtask

  // Expected response for one request, then the model update
  task automatic model_apply(input stim_t s, output store_res_t er);
    int hit_way;
    int vic;
    int w;
    er      = '0;
    hit_way = -1;
    vic     = -1;
    w       = 0;
    if (s.mode == Flush) begin
      for (int i = 0; i < `TS_WAYS; i++) begin
        if (s.ind[i]) begin
          w = i;
        end
      end
      er.indicator = s.ind;
      er.evict     = model_q[s.index][w].valid & model_q[s.index][w].dirty;
      er.evict_tag = model_q[s.index][w].tag;
      model_q[s.index][w] = '0;
    end else begin
      for (int i = 0; i < `TS_WAYS; i++) begin
        if (s.ind[i] && model_q[s.index][i].valid && model_q[s.index][i].tag == s.tag) begin
          hit_way = i;
        end
      end
      if (hit_way >= 0) begin
        er.indicator = way_ind_t'(1) << hit_way;
        er.hit       = 1'b1;
        model_q[s.index][hit_way].dirty = model_q[s.index][hit_way].dirty | s.dirty;
      end else begin
        // Lowest unlocked empty way first
        for (int i = 0; i < `TS_WAYS; i++) begin
          if (vic < 0 && !s.lock[i] && !model_q[s.index][i].valid) begin
            vic = i;
          end
        end
        // Set full, walk from the pointer
        if (vic < 0) begin
          for (int k = 0; k < `TS_WAYS; k++) begin
            w = (rr_ptr + k) % `TS_WAYS;
            if (vic < 0 && !s.lock[w]) begin
              vic = w;
            end
          end
          rr_ptr       = (vic + 1) % `TS_WAYS;
          er.evict     = model_q[s.index][vic].dirty;
          er.evict_tag = er.evict ? model_q[s.index][vic].tag : '0;
        end
        er.indicator = way_ind_t'(1) << vic;
        model_q[s.index][vic] = '{valid: 1'b1, dirty: s.dirty, tag: s.tag};
      end
    end
  endtask

  // Array contents against the model after the last request
  task automatic check_final_state();
    for (int i = 0; i < NumSets; i++) begin
      check_eq($sformatf("set %0d way 0", i),
               64'(u_tag_store.gen_macro[0].u_macro.mem_q[i]), 64'(model_q[i][0]));
      check_eq($sformatf("set %0d way 1", i),
               64'(u_tag_store.gen_macro[1].u_macro.mem_q[i]), 64'(model_q[i][1]));
      check_eq($sformatf("set %0d way 2", i),
               64'(u_tag_store.gen_macro[2].u_macro.mem_q[i]), 64'(model_q[i][2]));
      check_eq($sformatf("set %0d way 3", i),
               64'(u_tag_store.gen_macro[3].u_macro.mem_q[i]), 64'(model_q[i][3]));
    end
  endtask

  // Run limit and assertion watch
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (max_cycles != 0 && cycle_cnt >= max_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", max_cycles);
      stop_on_failure();
    end else if (u_tag_store.u_chk.fail_cnt != 0) begin
      $display("A protocol assertion failed, see the error above");
      stop_on_failure();
    end
  end

  initial begin
    stim_t       s;
    store_res_t  exp_res;
    store_res_t  held_res;
    int unsigned hold;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    spm_lock  = '0;
    res_ready = 1'b0;
    lfsr_q    = 32'h1897237c;
    rr_ptr    = 0;
    for (int i = 0; i < NumSets; i++) begin
      for (int w = 0; w < `TS_WAYS; w++) begin
        model_q[i][w] = '0;
      end
    end
    build_table();
    max_cycles = CyclesPerReq * stim_q.size() + ResetCycles;
    repeat (ResetCycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
    step();
    foreach (stim_q[n]) begin
      s = stim_q[n];
      model_apply(s, exp_res);
      req       = '{mode: s.mode, index: s.index, tag: s.tag, dirty: s.dirty, indicator: s.ind};
      spm_lock  = s.lock;
      req_valid = 1'b1;
      while (!req_ready) begin
        step();
      end
      // Accepting edge
      step();
      req_valid = 1'b0;
      while (!res_valid) begin
        check_eq($sformatf("entry %0d ready_o while busy", n), 64'(req_ready), 64'(0));
        step();
      end
      // Random stall on the response side
      rand_bits(2, hold);
      held_res = res;
      repeat (hold) begin
        step();
        check_eq($sformatf("entry %0d valid_o stalled", n), 64'(res_valid), 64'(1));
        check_eq($sformatf("entry %0d res_o stalled", n), 64'(res), 64'(held_res));
        check_eq($sformatf("entry %0d ready_o stalled", n), 64'(req_ready), 64'(0));
      end
      check_eq($sformatf("entry %0d response", n), 64'(res), 64'(exp_res));
      check_eq($sformatf("entry %0d hit", n), 64'(res.hit), 64'(s.exp_hit));
      check_eq($sformatf("entry %0d evict", n), 64'(res.evict), 64'(s.exp_evict));
      res_ready = 1'b1;
      step();
      res_ready = 1'b0;
    end
    step();
    check_final_state();
    if (u_tag_store.u_chk.fail_cnt != 0) begin
      $display("A protocol assertion failed during the run");
      stop_on_failure();
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

//--- filelist.f
+incdir+include
logic/tag_store_pkg.sv
logic/tag_macro.sv
logic/tag_compare.sv
logic/evict_select.sv
logic/tag_store_ctrl.sv
logic/tag_store.sv
test/tb_clock.sv
test/tag_store_chk.sv
test/tag_store_tb.sv

//--- Makefile
TOP := tag_store_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100

clean:
	rm -rf obj_dir
